/* logic/sqrt_fmt_pkg.sv */
`default_nettype none

// Number formats for the Q8.8 square-root engine
package sqrt_fmt_pkg;

    localparam int RAD_W    = 16;                   // Q8.8 radicand
    localparam int FRAC_W   = 8;                    // Fraction bits of the radicand
    localparam int ROOT_W   = (RAD_W + FRAC_W) / 2; // Q4.8 root, 12 bits
    localparam int REM_W    = ROOT_W + 2;           // Partial remainder
    localparam int ITER_MAX = ROOT_W;               // Bit pairs in a padded radicand
    localparam int CNT_W    = 4;                    // Holds 0..ITER_MAX

    // Two units side by side; dispatcher and reorder stage assume exactly two
    localparam int N_UNITS  = 2;

    typedef logic [RAD_W-1:0]  radicand_t;
    typedef logic [ROOT_W-1:0] root_t;
    typedef logic [REM_W-1:0]  rem_t;                // Unit internal only

endpackage

`default_nettype wire

/* logic/sqrt_xfer_pkg.sv */
`default_nettype none

// Records passed between dispatcher, root units and reorder stage
package sqrt_xfer_pkg;

    // Job handed to a unit
    // tag is the unit index the dispatcher picked
    typedef struct packed {
        sqrt_fmt_pkg::radicand_t rad;   // Q8.8 input sample
        logic                    tag;   // Target unit
    } sqrt_job_t;                       // 17 bits

    // Result of one job
    typedef struct packed {
        sqrt_fmt_pkg::root_t root;      // Q4.8 floor root
        logic                exact;     // Remainder was zero
    } sqrt_rsp_t;                       // 13 bits

endpackage

`default_nettype wire

/* logic/sqrt_dispatch.sv */
`default_nettype none

// Input side of the engine
// Accepts a strobe while busy is low and hands the job to units 0, 1, 0, 1, ...
module sqrt_dispatch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  sqrt_fmt_pkg::radicand_t   in_data,
    input  logic [1:0]                unit_idle,
    input  logic [1:0]                slot_full,
    output logic [1:0]                start,
    output sqrt_xfer_pkg::sqrt_job_t  job,
    output logic                      busy
);

    logic target_q;     // Unit that gets the next job
    logic issue_q;      // A job was taken at the last edge
    logic accept;

    // Target unit still working, or its result not yet drained
    assign busy   = ~unit_idle[target_q] | slot_full[target_q];
    assign accept = in_valid & ~busy;

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_q <= 1'b0;                   // Unit 0 first after reset
            issue_q  <= 1'b0;
        end else begin
            issue_q <= accept;                  // One cycle pulse per job
            if (accept) begin
                target_q <= ~target_q;          // Strict alternation
            end
        end
    end

    // Job payload, held until the next accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            job.rad <= in_data;
            job.tag <= target_q;
        end
    end

    // Start decoded from the registered tag
    // so the pulse and the job bus change on the same edge
    assign start = issue_q ? (2'b01 << job.tag) : 2'b00;

endmodule

`default_nettype wire

/* logic/sqrt_iter_unit.sv */
`default_nettype none

// Digit-by-digit square root, two radicand bits per iteration
// Leading zero bit pairs are skipped, so latency follows the value
module sqrt_iter_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  sqrt_xfer_pkg::sqrt_job_t  job,
    output logic                      idle,
    output logic                      done,
    output sqrt_xfer_pkg::sqrt_rsp_t  rsp
);

    import sqrt_fmt_pkg::*;

    localparam int PAD_W = RAD_W + FRAC_W;      // Radicand shifted up by the fraction

    typedef enum logic [1:0] {
        S_IDLE,
        S_BRING,    // Bring down a pair, form trial divisor and compare
        S_SELECT,   // Pick root bit and remainder
        S_DONE
    } state_t;

    state_t              state_q;
    logic [CNT_W-1:0]    cnt_q;         // Iterations still to go
    logic [CNT_W-1:0]    n_sig;         // Significant pairs of the new job
    logic [PAD_W-1:0]    pad;
    logic [PAD_W-1:0]    x_q;           // Remaining pairs, next one at the top
    root_t               root_q;
    rem_t                rem_q;
    rem_t                rem_sh_q;      // Remainder with the pair brought down
    rem_t                diff_q;        // rem_sh_q minus trial divisor
    logic                ge_q;          // Trial divisor fits
    rem_t                rem_trial;
    rem_t                divisor;
    rem_t                rem_next;
    root_t               root_next;

    // Number of bit pairs up to and including the top nonzero one, at least 1
    function automatic logic [CNT_W-1:0] sig_pairs(input logic [PAD_W-1:0] v);
        logic [CNT_W-1:0] n;
        n = CNT_W'(1);
        for (int i = 0; i < ITER_MAX; i++) begin
            if (v[2*i +: 2] != 2'b00) begin
                n = CNT_W'(i + 1);
            end
        end
        return n;
    endfunction

    assign pad   = {job.rad, {FRAC_W{1'b0}}};
    assign n_sig = sig_pairs(pad);

    // Stage one arithmetic
    assign rem_trial = {rem_q[REM_W-3:0], x_q[PAD_W-1 -: 2]};   // (rem << 2) | pair
    assign divisor   = {root_q, 2'b01};                         // (root << 2) + 1

    // Stage two selection
    assign root_next = {root_q[ROOT_W-2:0], ge_q};
    assign rem_next  = ge_q ? diff_q : rem_sh_q;

    assign idle = (state_q == S_IDLE);
    assign done = (state_q == S_DONE);      // Idle again only after the pulse

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start) begin
                        state_q <= S_BRING;
                        cnt_q   <= n_sig;
                    end
                end
                S_BRING:  state_q <= S_SELECT;
                S_SELECT: begin
                    cnt_q   <= cnt_q - 1'b1;
                    state_q <= (cnt_q == CNT_W'(1)) ? S_DONE : S_BRING;
                end
                default:  state_q <= S_IDLE;    // S_DONE lasts one cycle
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        case (state_q)
            S_IDLE: begin
                if (start) begin
                    // Drop the leading zero pairs
                    x_q    <= pad << (2 * (ITER_MAX - int'(n_sig)));
                    root_q <= '0;
                    rem_q  <= '0;
                end
            end
            S_BRING: begin
                rem_sh_q <= rem_trial;
                diff_q   <= rem_trial - divisor;
                ge_q     <= (rem_trial >= divisor);
                x_q      <= x_q << 2;           // Next pair to the top
            end
            S_SELECT: begin
                root_q <= root_next;
                rem_q  <= rem_next;
                if (cnt_q == CNT_W'(1)) begin
                    rsp.root  <= root_next;
                    rsp.exact <= (rem_next == '0);  // No remainder left
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/sqrt_reorder.sv */
`default_nettype none

// Merges the two unit result streams back into input order
// Jobs alternate between units, so the head pointer alternates too
module sqrt_reorder (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [1:0]                      done,
    input  sqrt_xfer_pkg::sqrt_rsp_t [1:0]  rsp_in,
    output logic [1:0]                      slot_full,
    output logic                            out_valid,
    output sqrt_xfer_pkg::sqrt_rsp_t        out_data
);

    import sqrt_fmt_pkg::*;
    import sqrt_xfer_pkg::*;

    sqrt_rsp_t slot_q [N_UNITS];    // One parked result per unit
    logic      head_q;              // Slot owed next to the output
    logic      head_ready;

    // Head result parked, or arriving right now
    assign head_ready = slot_full[head_q] | done[head_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_full <= '0;
            head_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            for (int i = 0; i < N_UNITS; i++) begin
                if (head_ready && head_q == 1'(i)) begin
                    slot_full[i] <= 1'b0;           // Drained, or passed straight through
                end else if (done[i] && head_q != 1'(i)) begin
                    slot_full[i] <= 1'b1;           // Early finisher waits here
                end
            end
            out_valid <= head_ready;                // At most one per cycle
            if (head_ready) begin
                head_q <= ~head_q;
            end
        end
    end

    // Result storage and output register
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_UNITS; i++) begin
            if (done[i]) begin
                slot_q[i] <= rsp_in[i];
            end
        end
        if (head_ready) begin
            // Parked copy wins; otherwise bypass the fresh result
            out_data <= slot_full[head_q] ? slot_q[head_q] : rsp_in[head_q];
        end
    end

endmodule

`default_nettype wire

/* logic/sqrt_pair_top.sv */
`default_nettype none

// Q8.8 square-root engine with two iterative units
// Dispatcher -> two root units -> reorder stage
module sqrt_pair_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  sqrt_fmt_pkg::radicand_t   in_data,
    output logic                      busy,
    output logic                      out_valid,
    output sqrt_xfer_pkg::sqrt_rsp_t  out_data
);

    import sqrt_fmt_pkg::*;
    import sqrt_xfer_pkg::*;

    sqrt_job_t                  job;            // Shared job bus
    logic      [N_UNITS-1:0]    start;
    logic      [N_UNITS-1:0]    unit_idle;
    logic      [N_UNITS-1:0]    unit_done;
    logic      [N_UNITS-1:0]    slot_full;
    sqrt_rsp_t [N_UNITS-1:0]    unit_rsp;

    sqrt_dispatch u_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .unit_idle (unit_idle),
        .slot_full (slot_full),
        .start     (start),
        .job       (job),
        .busy      (busy)
    );

    for (genvar u = 0; u < N_UNITS; u++) begin : g_unit
        sqrt_iter_unit u_unit (
            .clk   (clk),
            .rst_n (rst_n),
            .start (start[u]),          // Only this unit's pulse, bus is shared
            .job   (job),
            .idle  (unit_idle[u]),
            .done  (unit_done[u]),
            .rsp   (unit_rsp[u])
        );
    end

    sqrt_reorder u_reorder (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (unit_done),
        .rsp_in    (unit_rsp),
        .slot_full (slot_full),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

/* include/sqrt_tb_util.svh */
`ifndef SQRT_TB_UTIL_SVH
`define SQRT_TB_UTIL_SVH

// Reference model and checking helpers for the square-root testbench

// Floor root of rad * 256 and the exact bit in the sqrt_rsp_t layout
function automatic logic [12:0] ref_sqrt(input logic [15:0] rad);
    int unsigned value;
    int unsigned r;
    logic        exact;
    value = int'(rad) * 256;            // Radicand padded with the fraction bits
    r     = 0;
    while ((r + 1) * (r + 1) <= value) begin
        r++;                            // Plain linear search
    end
    exact = (r * r == value);
    return {r[11:0], exact};
endfunction

// First mismatch ends the run
task automatic tb_fail(input string msg);
    $display("ERR %s", msg);
    $display("TB FAILED");
    $fatal(1, "%s", msg);
endtask

// Compare one field and show both values in hex
task automatic check_field(
    input string       name,
    input logic [15:0] rad,
    input logic [31:0] got,
    input logic [31:0] exp
);
    string msg;
    if (got !== exp) begin
        msg = $sformatf("%s for radicand 0x%04h: got 0x%0h, expected 0x%0h",
                        name, rad, got, exp);
        tb_fail(msg);
    end
endtask

// Check a whole result record against the reference
task automatic check_rsp(input logic [15:0] rad, input logic [12:0] got);
    logic [12:0] exp;
    exp = ref_sqrt(rad);
    check_field("out_data.root", rad, got[12:1], exp[12:1]);
    check_field("out_data.exact", rad, got[0], exp[0]);
endtask

`endif

/* bench/sqrt_pair_tb.sv */
`default_nettype none

module sqrt_pair_tb;

    import sqrt_fmt_pkg::*;
    import sqrt_xfer_pkg::*;

    `include "sqrt_tb_util.svh"

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 16;
    localparam int N_DIRECTED = 6;
    localparam int N_BURST    = 4;                  // Two pairs of a large radicand then a small one
    localparam int N_RAND     = 300;
    localparam int N_JOBS     = N_DIRECTED + N_BURST + N_RAND;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    radicand_t in_data;
    logic      busy;
    logic      out_valid;
    sqrt_rsp_t out_data;

    radicand_t exp_q[$];                            // Accepted radicands, oldest first
    int        sent;                                // Strobes driven
    int        accepted;                            // Strobes taken by the DUT
    int        recv;                                // Results seen on out_valid

    sqrt_pair_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Report a failure that is not a value mismatch, then stop
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    // Called on a falling edge; waits out busy while in_data keeps moving
    task automatic send_job(input radicand_t rad);
        while (busy) begin
            in_valid = 1'b0;
            in_data  = radicand_t'($urandom);       // Noise that must not be taken
            @(negedge clk);
        end
        in_valid = 1'b1;
        in_data  = rad;
        exp_q.push_back(rad);                       // busy is stable until the next rise
        sent     = sent + 1;
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = radicand_t'($urandom);
    endtask

    // Count what the DUT really took
    always @(posedge clk) begin
        if (rst_n && in_valid && !busy) begin
            accepted = accepted + 1;
        end
    end

    // Results are checked in order against the reference
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            recv = recv + 1;
        end
        if (accepted - recv > 2) begin
            abort_run($sformatf("More than two jobs in flight (%0d accepted, %0d returned)",
                                accepted, recv));
        end else if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("A result came out with no job outstanding");
            end else begin
                check_rsp(exp_q.pop_front(), out_data);
            end
        end
    end

    // Stimulus
    initial begin
        radicand_t rad;
        void'($urandom(32'h9654018b));
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        sent     = 0;
        accepted = 0;
        recv     = 0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (busy !== 1'b0 || out_valid !== 1'b0) begin
            abort_run("busy or out_valid is not low after reset");
        end
        repeat (10) @(negedge clk);                 // Nothing may come out of an idle engine

        send_job(16'h0000);
        send_job(16'h0001);
        send_job(16'h0100);                         // 1.0 in, root 1.0 and exact
        send_job(16'hFFFF);
        send_job(16'h0400);
        send_job(16'h0002);

        // Long job first, short one overtakes inside the units
        send_job(16'hFFFF);
        send_job(16'h0001);
        send_job(16'hF000);
        send_job(16'h0000);

        for (int i = 0; i < N_RAND; i++) begin
            rad = radicand_t'($urandom) >> ($urandom % 16);    // Spread the latencies
            send_job(rad);
        end

        wait (recv == N_JOBS);
        repeat (40) @(negedge clk);                 // Watch for stray results
        if (recv != N_JOBS || accepted != sent || exp_q.size() != 0) begin
            abort_run($sformatf("Job count mismatch: %0d sent, %0d accepted, %0d returned",
                                sent, accepted, recv));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // Watchdog allows 40 cycles per job plus reset
    initial begin
        #((N_JOBS * 40 + RST_CYCLES) * CLK_PERIOD);
        abort_run($sformatf("Timeout: the engine hung after %0d of %0d results",
                            recv, N_JOBS));
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
logic/sqrt_fmt_pkg.sv
logic/sqrt_xfer_pkg.sv
logic/sqrt_dispatch.sv
logic/sqrt_iter_unit.sv
logic/sqrt_reorder.sv
logic/sqrt_pair_top.sv
bench/sqrt_pair_tb.sv

/* Bender.yml */
package:
  name: sqrt_pair

sources:
  - files:
      - logic/sqrt_fmt_pkg.sv
      - logic/sqrt_xfer_pkg.sv
      - logic/sqrt_dispatch.sv
      - logic/sqrt_iter_unit.sv
      - logic/sqrt_reorder.sv
      - logic/sqrt_pair_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/sqrt_pair_tb.sv
